// File: verilog/i2c_types_pkg.sv
package i2c_types_pkg;

    localparam int BITS_PER_BYTE = 8;

    typedef logic [BITS_PER_BYTE-1:0] byte_t;
    typedef logic [6:0] dev_addr_t;
    typedef logic [2:0] byte_count_t;  // 1 to 4, zero counts as one

    typedef struct packed {
        logic        enable;
        logic        int_en;
        dev_addr_t   dev_addr;
        byte_t [3:0] data;             // Byte 0 goes out first
        byte_count_t byte_count;
    } i2c_cfg_t;

    typedef struct packed {
        logic busy;
        logic done;
        logic nack;
    } i2c_event_t;

    typedef enum logic [2:0] {
        IDLE,
        START,
        SHIFT,
        ACK,
        STOP_LOW,
        STOP_HIGH
    } engine_state_e;

endpackage

// File: verilog/apb_map_pkg.sv
package apb_map_pkg;

    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        apb_data_t pwdata;
    } apb_req_t;

    localparam apb_addr_t REG_CTRL     = 8'h00;
    localparam apb_addr_t REG_PRESCALE = 8'h04;
    localparam apb_addr_t REG_ADDR     = 8'h08;
    localparam apb_addr_t REG_DATA     = 8'h0C;
    localparam apb_addr_t REG_COUNT    = 8'h10;
    localparam apb_addr_t REG_STATUS   = 8'h14;

    localparam int CTRL_ENABLE_BIT   = 0;
    localparam int CTRL_INT_EN_BIT   = 1;
    localparam int CTRL_START_BIT    = 2;  // Write only
    localparam int STATUS_BUSY_BIT   = 0;
    localparam int STATUS_DONE_BIT   = 1;
    localparam int STATUS_ERROR_BIT  = 2;

endpackage

// File: verilog/apb_reg_decode.sv
`timescale 1ns/100ps

module apb_reg_decode import apb_map_pkg::*, i2c_types_pkg::*; #(
    parameter int PRESCALE_W = 16
) (
    input  logic                  clk,
    input  logic                  reset_i,
    input  apb_req_t              apb_req_i,
    input  logic                  busy_i,
    input  logic                  done_i,
    input  logic                  error_i,
    output apb_data_t             prdata_o,
    output logic                  pready_o,
    output i2c_cfg_t              cfg_o,
    output logic [PRESCALE_W-1:0] prescale_o,
    output logic                  start_o,
    output logic                  clear_done_o,
    output logic                  clear_error_o
);

    logic                  access;
    logic                  wr_en;
    logic                  rd_en;
    apb_data_t             rd_data;
    logic                  enable_q;
    logic                  int_en_q;
    logic [PRESCALE_W-1:0] prescale_q;
    dev_addr_t             dev_addr_q;
    byte_t [3:0]           data_q;
    byte_count_t           count_q;

    assign access   = apb_req_i.psel && apb_req_i.penable;
    assign wr_en    = access && apb_req_i.pwrite;
    assign rd_en    = access && !apb_req_i.pwrite;
    assign pready_o = 1'b1;  // Zero wait states

    always_ff @(posedge clk) begin
        if (reset_i) begin
            enable_q   <= 1'b0;
            int_en_q   <= 1'b0;
            prescale_q <= '0;
            count_q    <= byte_count_t'(1);
        end else if (wr_en) begin
            case (apb_req_i.paddr)
                REG_CTRL: begin
                    enable_q <= apb_req_i.pwdata[CTRL_ENABLE_BIT];
                    int_en_q <= apb_req_i.pwdata[CTRL_INT_EN_BIT];
                end
                REG_PRESCALE: prescale_q <= apb_req_i.pwdata[PRESCALE_W-1:0];
                REG_COUNT:    count_q    <= apb_req_i.pwdata[$bits(byte_count_t)-1:0];
                default: ;
            endcase
        end
    end

    // Target address and payload
    always_ff @(posedge clk) begin
        if (wr_en && apb_req_i.paddr == REG_ADDR) begin
            dev_addr_q <= apb_req_i.pwdata[$bits(dev_addr_t)-1:0];
        end
        if (wr_en && apb_req_i.paddr == REG_DATA) begin
            data_q <= apb_req_i.pwdata;
        end
    end

    // Start only when enabled in the same write and the engine is idle
    assign start_o = wr_en && apb_req_i.paddr == REG_CTRL
                     && apb_req_i.pwdata[CTRL_START_BIT]
                     && apb_req_i.pwdata[CTRL_ENABLE_BIT] && !busy_i;

    assign clear_done_o  = wr_en && apb_req_i.paddr == REG_STATUS
                           && apb_req_i.pwdata[STATUS_DONE_BIT];
    assign clear_error_o = wr_en && apb_req_i.paddr == REG_STATUS
                           && apb_req_i.pwdata[STATUS_ERROR_BIT];

    always_comb begin
        rd_data = '0;
        case (apb_req_i.paddr)
            REG_CTRL: begin
                rd_data[CTRL_ENABLE_BIT] = enable_q;
                rd_data[CTRL_INT_EN_BIT] = int_en_q;
            end
            REG_PRESCALE: rd_data = apb_data_t'(prescale_q);
            REG_ADDR:     rd_data = apb_data_t'(dev_addr_q);
            REG_DATA:     rd_data = data_q;
            REG_COUNT:    rd_data = apb_data_t'(count_q);
            REG_STATUS: begin
                rd_data[STATUS_BUSY_BIT]  = busy_i;
                rd_data[STATUS_DONE_BIT]  = done_i;
                rd_data[STATUS_ERROR_BIT] = error_i;
            end
            default: ;  // Unmapped reads as zero
        endcase
    end

    assign prdata_o   = rd_en ? rd_data : '0;
    assign prescale_o = prescale_q;

    assign cfg_o = '{
        enable:     enable_q,
        int_en:     int_en_q,
        dev_addr:   dev_addr_q,
        data:       data_q,
        byte_count: count_q
    };

    // An accepted start finds the engine idle and makes it busy next cycle
    a_start_idle: assert property (@(posedge clk) disable iff (reset_i)
        start_o |-> !busy_i ##1 busy_i);

endmodule

// File: verilog/i2c_scl_gen.sv
`timescale 1ns/100ps

module i2c_scl_gen #(
    parameter int PRESCALE_W = 16
) (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  run_i,
    input  logic [PRESCALE_W-1:0] prescale_i,
    output logic                  scl_o,
    output logic                  scl_rise_o,
    output logic                  scl_fall_o
);

    logic [PRESCALE_W-1:0] cnt_q;
    logic                  scl_q;
    logic                  rise_q;
    logic                  fall_q;
    logic                  wrap;

    // Also wraps if the prescaler is lowered mid count
    assign wrap = (cnt_q >= prescale_i);

    always_ff @(posedge clk) begin
        if (reset_i || !run_i) begin
            cnt_q  <= '0;
            scl_q  <= 1'b1;  // Bus idle level
            rise_q <= 1'b0;
            fall_q <= 1'b0;
        end else begin
            rise_q <= wrap && !scl_q;
            fall_q <= wrap && scl_q;
            if (wrap) begin
                cnt_q <= '0;
                scl_q <= !scl_q;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    assign scl_o      = scl_q;
    assign scl_rise_o = rise_q;
    assign scl_fall_o = fall_q;

    // Strobes are exclusive and mark a real change of SCL
    a_scl_strobes: assert property (@(posedge clk) disable iff (reset_i)
        (scl_rise_o || scl_fall_o) |->
            !(scl_rise_o && scl_fall_o) && (scl_o != $past(scl_o)));

endmodule

// File: verilog/i2c_write_engine.sv
`timescale 1ns/100ps

module i2c_write_engine import i2c_types_pkg::*; (
    input  logic       clk,
    input  logic       reset_i,
    input  logic       start_i,
    input  i2c_cfg_t   cfg_i,
    input  logic       scl_rise_i,
    input  logic       scl_fall_i,
    input  logic       sda_i,
    output logic       run_o,
    output logic       sda_oe_o,
    output i2c_event_t evt_o
);

    engine_state_e                    state_q;
    byte_t                            shift_q;
    byte_t [3:0]                      data_q;
    logic [$clog2(BITS_PER_BYTE)-1:0] bit_cnt_q;
    byte_count_t                      bytes_left_q;
    byte_count_t                      count_eff;
    logic                             nack_q;
    logic                             sda_oe_q;
    logic                             done_q;
    logic                             nack_evt_q;
    logic                             next_byte;

    always_comb begin
        if (cfg_i.byte_count == '0) begin
            count_eff = byte_count_t'(1);
        end else if (cfg_i.byte_count > byte_count_t'(4)) begin
            count_eff = byte_count_t'(4);
        end else begin
            count_eff = cfg_i.byte_count;
        end
    end

    // Acked and more bytes to go
    assign next_byte = scl_fall_i && !nack_q && bytes_left_q != '0;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q      <= IDLE;
            sda_oe_q     <= 1'b0;
            bit_cnt_q    <= '0;
            bytes_left_q <= '0;
            nack_q       <= 1'b0;
            done_q       <= 1'b0;
            nack_evt_q   <= 1'b0;
        end else begin
            done_q     <= 1'b0;
            nack_evt_q <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        state_q      <= START;
                        sda_oe_q     <= 1'b1;  // START, SDA falls with SCL high
                        bytes_left_q <= count_eff;
                        nack_q       <= 1'b0;
                    end
                end
                START: begin
                    if (scl_fall_i) begin
                        state_q   <= SHIFT;
                        bit_cnt_q <= '0;
                        sda_oe_q  <= !shift_q[BITS_PER_BYTE-1];
                    end
                end
                SHIFT: begin
                    if (scl_fall_i) begin
                        if (bit_cnt_q == BITS_PER_BYTE - 1) begin
                            state_q  <= ACK;
                            sda_oe_q <= 1'b0;  // Slave owns the ninth bit
                        end else begin
                            bit_cnt_q <= bit_cnt_q + 1'b1;
                            sda_oe_q  <= !shift_q[BITS_PER_BYTE-2];
                        end
                    end
                end
                ACK: begin
                    if (scl_rise_i) begin
                        nack_q <= sda_i;
                    end else if (next_byte) begin
                        state_q      <= SHIFT;
                        bit_cnt_q    <= '0;
                        bytes_left_q <= bytes_left_q - 1'b1;
                        sda_oe_q     <= !data_q[0][BITS_PER_BYTE-1];
                    end else if (scl_fall_i) begin
                        state_q  <= STOP_LOW;
                        sda_oe_q <= 1'b1;
                    end
                end
                STOP_LOW: begin
                    if (scl_rise_i) begin
                        state_q  <= STOP_HIGH;
                        sda_oe_q <= 1'b0;  // STOP, SDA rises with SCL high
                    end
                end
                STOP_HIGH: begin
                    state_q    <= IDLE;
                    done_q     <= !nack_q;
                    nack_evt_q <= nack_q;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Byte shifter and the latched data word
    always_ff @(posedge clk) begin
        if (state_q == IDLE && start_i) begin
            shift_q <= {cfg_i.dev_addr, 1'b0};  // R/W low
            data_q  <= cfg_i.data;
        end else if (state_q == SHIFT && scl_fall_i) begin
            shift_q <= shift_q << 1;
        end else if (state_q == ACK && next_byte) begin
            shift_q <= data_q[0];
            data_q  <= data_q >> BITS_PER_BYTE;
        end
    end

    // Park SCL high as soon as the STOP rise is seen
    assign run_o = state_q != IDLE && state_q != STOP_HIGH
                   && !(state_q == STOP_LOW && scl_rise_i);

    assign sda_oe_o = sda_oe_q;

    assign evt_o = '{
        busy: state_q != IDLE,
        done: done_q,
        nack: nack_evt_q
    };

    a_state_legal: assert property (@(posedge clk) disable iff (reset_i)
        state_q inside {IDLE, START, SHIFT, ACK, STOP_LOW, STOP_HIGH});

endmodule

// File: verilog/i2c_status_result.sv
`timescale 1ns/100ps

module i2c_status_result import i2c_types_pkg::*; (
    input  logic       clk,
    input  logic       reset_i,
    input  i2c_event_t evt_i,
    input  logic       int_en_i,
    input  logic       clear_done_i,
    input  logic       clear_error_i,
    output logic       done_o,
    output logic       error_o,
    output logic       irq_o
);

    logic done_q;
    logic error_q;

    // Set wins over a clear in the same cycle
    always_ff @(posedge clk) begin
        if (reset_i) begin
            done_q  <= 1'b0;
            error_q <= 1'b0;
        end else begin
            if (evt_i.done) begin
                done_q <= 1'b1;
            end else if (clear_done_i) begin
                done_q <= 1'b0;
            end
            if (evt_i.nack) begin
                error_q <= 1'b1;
            end else if (clear_error_i) begin
                error_q <= 1'b0;
            end
        end
    end

    assign done_o  = done_q;
    assign error_o = error_q;
    assign irq_o   = int_en_i && (done_q || error_q);

    // A result closes exactly one transfer
    a_result_end: assert property (@(posedge clk) disable iff (reset_i)
        (evt_i.done || evt_i.nack) |->
            !(evt_i.done && evt_i.nack) && !evt_i.busy && $past(evt_i.busy));

endmodule

// File: verilog/i2c_master_top.sv
`timescale 1ns/100ps

module i2c_master_top import apb_map_pkg::*, i2c_types_pkg::*; #(
    parameter int PRESCALE_W = 16
) (
    input  logic      clk,
    input  logic      reset_i,
    input  apb_req_t  apb_req_i,
    output apb_data_t prdata_o,
    output logic      pready_o,
    output logic      irq_o,
    output logic      scl_o,
    output logic      sda_oe_o,
    input  logic      sda_i
);

    i2c_cfg_t              cfg;
    logic [PRESCALE_W-1:0] prescale;
    logic                  start_pulse;
    logic                  clear_done;
    logic                  clear_error;
    logic                  run;
    logic                  scl_rise;
    logic                  scl_fall;
    i2c_event_t            evt;
    logic                  done;
    logic                  error;

    apb_reg_decode #(.PRESCALE_W(PRESCALE_W)) u_decode (
        .clk(clk), .reset_i(reset_i), .apb_req_i(apb_req_i),
        .busy_i(evt.busy), .done_i(done), .error_i(error),
        .prdata_o(prdata_o), .pready_o(pready_o), .cfg_o(cfg), .prescale_o(prescale),
        .start_o(start_pulse), .clear_done_o(clear_done), .clear_error_o(clear_error)
    );

    i2c_scl_gen #(.PRESCALE_W(PRESCALE_W)) u_scl_gen (
        .clk(clk), .reset_i(reset_i), .run_i(run), .prescale_i(prescale),
        .scl_o(scl_o), .scl_rise_o(scl_rise), .scl_fall_o(scl_fall)
    );

    i2c_write_engine u_engine (
        .clk(clk), .reset_i(reset_i), .start_i(start_pulse), .cfg_i(cfg),
        .scl_rise_i(scl_rise), .scl_fall_i(scl_fall), .sda_i(sda_i),
        .run_o(run), .sda_oe_o(sda_oe_o), .evt_o(evt)
    );

    i2c_status_result u_result (
        .clk(clk), .reset_i(reset_i), .evt_i(evt), .int_en_i(cfg.int_en),
        .clear_done_i(clear_done), .clear_error_i(clear_error),
        .done_o(done), .error_o(error), .irq_o(irq_o)
    );

endmodule

// File: verification/i2c_slave_model.sv
`timescale 1ns/100ps

module i2c_slave_model import i2c_types_pkg::*; #(
    parameter dev_addr_t NACK_ADDR = 7'h5A
) (
    input  logic        scl_i,
    input  logic        sda_i,
    output logic        sda_pull_o,
    output int          start_cnt_o,
    output int          stop_cnt_o,
    output int          rec_cnt_o,
    output byte_t [4:0] rec_o
);

    logic  scl_prev;
    logic  sda_prev;
    logic  in_frame;
    int    bit_cnt;
    byte_t shreg;

    initial begin
        sda_pull_o  = 1'b0;
        start_cnt_o = 0;
        stop_cnt_o  = 0;
        rec_cnt_o   = 0;
        rec_o       = '0;
        scl_prev    = 1'b1;
        sda_prev    = 1'b1;
        in_frame    = 1'b0;
        bit_cnt     = 0;
        shreg       = '0;
    end

    always @(scl_i or sda_i) begin
        if (scl_i && scl_prev && sda_prev && !sda_i) begin
            start_cnt_o = start_cnt_o + 1;  // START
            in_frame    = 1'b1;
            bit_cnt     = 0;
            rec_cnt_o   = 0;
        end else if (scl_i && scl_prev && !sda_prev && sda_i && in_frame) begin
            stop_cnt_o = stop_cnt_o + 1;  // STOP
            in_frame   = 1'b0;
        end else if (scl_i && !scl_prev && in_frame && bit_cnt < 8) begin
            shreg   = {shreg[6:0], sda_i};
            bit_cnt = bit_cnt + 1;
            if (bit_cnt == 8) begin
                if (rec_cnt_o < 5) rec_o[rec_cnt_o] = shreg;
                rec_cnt_o = rec_cnt_o + 1;
            end
        end else if (!scl_i && scl_prev && in_frame) begin
            if (bit_cnt == 8) begin
                // NACK only the blocked address
                sda_pull_o = !(rec_cnt_o == 1 && shreg[7:1] == NACK_ADDR);
                bit_cnt    = 9;
            end else if (bit_cnt == 9) begin
                sda_pull_o = 1'b0;
                bit_cnt    = 0;
            end
        end
        scl_prev = scl_i;
        sda_prev = sda_i;
    end

endmodule

// File: verification/i2c_master_tb.sv
`timescale 1ns/100ps

module i2c_master_tb import apb_map_pkg::*, i2c_types_pkg::*;;

    localparam int PRESCALE = 4;
    localparam int TIMEOUT_CYCLES = 6 * 45 * 2 * (PRESCALE + 1) + 3000;

    logic clk, reset_i, sda, slave_pull, chk_valid, scl_d, have_edge;
    apb_req_t apb_req;
    apb_data_t prdata, rd, chk_exp, chk_act;
    logic pready, irq, scl, sda_oe;
    int start_cnt, stop_cnt, rec_cnt, starts_exp, mismatch_cnt, fail_cnt, cycle_cnt, since_edge;
    byte_t [4:0] rec;
    string chk_name;
    logic [31:0] lfsr_q, rnd;

    assign sda = !(sda_oe || slave_pull);  // Open-drain wired AND

    i2c_master_top #(.PRESCALE_W(16)) dut_i (
        .clk(clk), .reset_i(reset_i), .apb_req_i(apb_req), .prdata_o(prdata),
        .pready_o(pready), .irq_o(irq), .scl_o(scl), .sda_oe_o(sda_oe), .sda_i(sda)
    );

    i2c_slave_model slave_i (
        .scl_i(scl), .sda_i(sda), .sda_pull_o(slave_pull), .start_cnt_o(start_cnt),
        .stop_cnt_o(stop_cnt), .rec_cnt_o(rec_cnt), .rec_o(rec)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = !clk;
    end

    // Half-period counter between SCL edges of one transfer
    always_ff @(posedge clk) begin
        if (reset_i) begin
            scl_d      <= 1'b1;
            since_edge <= 0;
            have_edge  <= 1'b0;
        end else begin
            scl_d <= scl;
            since_edge <= (scl != scl_d) ? 1 : since_edge + 1;
            if (!dut_i.evt.busy) have_edge <= 1'b0;
            else if (scl != scl_d) have_edge <= 1'b1;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("timeout: transfers did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
            $display("test failed");
            $finish;
        end
    end

    a_value: assert property (@(posedge clk) chk_valid |-> chk_exp == chk_act)
        else begin
            mismatch_cnt++;
            $display("mismatch %s: expected %h actual %h", chk_name, chk_exp, chk_act);
        end
    a_scl_half: assert property (@(posedge clk) disable iff (reset_i)
        (scl != scl_d && have_edge) |-> since_edge == PRESCALE + 1)
        else begin
            mismatch_cnt++;
            $display("mismatch scl_half_period: expected %0d actual %0d",
                     PRESCALE + 1, $sampled(since_edge));
        end
    a_pready: assert property (@(posedge clk) apb_req.psel |-> pready)
        else begin
            fail_cnt++;
            $display("PREADY was low during an APB access");
        end

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic        fb;
        logic [31:0] v;
        v = '0;
        repeat (n) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            v      = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        @(negedge clk);
        chk_name  = name;
        chk_exp   = exp;
        chk_act   = act;
        chk_valid = 1'b1;
        @(negedge clk);
        chk_valid = 1'b0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
        @(negedge clk);
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
        @(negedge clk);
        apb_req.penable = 1'b1;
        @(negedge clk);
        apb_req = '0;
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t data);
        @(negedge clk);
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: '0};
        @(negedge clk);
        apb_req.penable = 1'b1;
        #1 data = prdata;
        @(negedge clk);
        apb_req = '0;
    endtask

    task automatic run_transfer(input dev_addr_t addr, input int count, input apb_data_t data,
                                input logic nack_exp, input logic retry_start);
        apb_write(REG_ADDR, apb_data_t'(addr));
        apb_write(REG_DATA, data);
        apb_write(REG_COUNT, apb_data_t'(count));
        apb_write(REG_CTRL, 32'h7);
        if (retry_start) apb_write(REG_CTRL, 32'h7);  // Lands while busy
        starts_exp++;
        while (!irq) @(negedge clk);
        apb_read(REG_STATUS, rd);
        check_value("status", {29'd0, nack_exp, !nack_exp, 1'b0}, rd);
        check_value("start_count", starts_exp, start_cnt);
        check_value("stop_count", starts_exp, stop_cnt);
        check_value("byte_count", nack_exp ? 1 : count + 1, rec_cnt);
        check_value("addr_byte", {addr, 1'b0}, rec[0]);
        for (int i = 0; i < count && !nack_exp; i++) begin
            check_value("data_byte", data[8*i +: 8], rec[i+1]);
        end
        apb_write(REG_CTRL, 32'h1);  // Flag still set, interrupt masked
        check_value("irq_masked", 0, irq);
        apb_write(REG_CTRL, 32'h3);
        check_value("irq_set", 1, irq);
        apb_write(REG_STATUS, 32'h6);
        check_value("irq_cleared", 0, irq);
        apb_read(REG_STATUS, rd);
        check_value("status_cleared", 0, rd);
    endtask

    initial begin
        apb_req      = '0;
        reset_i      = 1'b1;
        chk_valid    = 1'b0;
        chk_name     = "";
        chk_exp      = '0;
        chk_act      = '0;
        lfsr_q       = 32'h126;
        starts_exp   = 0;
        mismatch_cnt = 0;
        fail_cnt     = 0;
        cycle_cnt    = 0;
        repeat (8) @(posedge clk);
        @(negedge clk) reset_i = 1'b0;
        check_value("reset_scl", 1, scl);
        check_value("reset_sda_oe", 0, sda_oe);
        check_value("reset_irq", 0, irq);
        apb_read(REG_STATUS, rd);
        check_value("reset_status", 0, rd);

        apb_write(REG_PRESCALE, PRESCALE);
        apb_read(REG_PRESCALE, rd);
        check_value("prescale_rb", PRESCALE, rd);
        apb_write(REG_ADDR, 32'h3C);
        apb_read(REG_ADDR, rd);
        check_value("addr_rb", 32'h3C, rd);
        rnd = rand_bits(32);
        apb_write(REG_DATA, rnd);
        apb_read(REG_DATA, rd);
        check_value("data_rb", rnd, rd);
        apb_write(REG_COUNT, 3);
        apb_read(REG_COUNT, rd);
        check_value("count_rb", 3, rd);
        apb_write(REG_CTRL, 32'h6);  // No enable, so no transfer
        apb_read(REG_CTRL, rd);
        check_value("ctrl_rb", 32'h2, rd);

        for (int n = 1; n <= 4; n++) begin
            rnd = rand_bits(32);
            run_transfer(7'h3C, n, rnd, 1'b0, 1'b0);
        end
        run_transfer(7'h5A, 2, 32'hA5C3, 1'b1, 1'b0);
        rnd = rand_bits(32);
        run_transfer(7'h3C, int'(rnd[1:0]) + 1, rnd, 1'b0, 1'b1);

        $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: all.f
verilog/i2c_types_pkg.sv
verilog/apb_map_pkg.sv
verilog/apb_reg_decode.sv
verilog/i2c_scl_gen.sv
verilog/i2c_write_engine.sv
verilog/i2c_status_result.sv
verilog/i2c_master_top.sv
verification/i2c_slave_model.sv
verification/i2c_master_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module i2c_master_tb -o i2c_master_sim
./obj_dir/i2c_master_sim | tee sim.log

if grep -q "test failed" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
if ! grep -q "test passed" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
